//--- hw/di_pkg.sv
// Shared types and constants for the decode-issue stage.
// Covers the RV32 subset add, addi, mul and lw only.
// Bit positions in op_vec_t follow the encoding of uop_t.

package di_pkg;

  // Data and address width
  localparam int XLEN = 32;

  // ------------------------------------------------------------
  // Micro-ops
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_ADDI = 2'd1,
    OP_MUL  = 2'd2,
    OP_LW   = 2'd3
  } uop_t;

  // One bit per micro-op, used to describe pipe capabilities
  typedef logic [3:0] op_vec_t;

  localparam op_vec_t OP_ADD_VEC  = 4'b0001;
  localparam op_vec_t OP_ADDI_VEC = 4'b0010;
  localparam op_vec_t OP_MUL_VEC  = 4'b0100;
  localparam op_vec_t OP_LW_VEC   = 4'b1000;
  localparam op_vec_t OP_ALL_VEC  = OP_ADD_VEC | OP_ADDI_VEC | OP_MUL_VEC | OP_LW_VEC;

  // ------------------------------------------------------------
  // RV32 encoding fields
  // ------------------------------------------------------------

  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Vector bit that matches a single micro-op
  function automatic op_vec_t uop_to_vec(input uop_t uop);
    op_vec_t vec;
    vec = op_vec_t'(1) << uop;
    return vec;
  endfunction

endpackage

//--- hw/di_ifs.sv
// Bundles used between the blocks of the decode-issue stage.
// dec_if carries the decoded fields of the held instruction.
// cmpl_if carries one completion writeback per cycle, no ready.

`timescale 1ns/100ps

interface dec_if import di_pkg::*; ();

  uop_t             uop;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [XLEN-1:0]  imm;
  logic             uses_rs2;
  logic             legal;

  modport producer (output uop, rs1, rs2, rd, imm, uses_rs2, legal);
  modport consumer (input uop, rs1, rs2, rd, imm, uses_rs2, legal);

  // Register file only needs the read indices
  modport reader (input rs1, rs2);

endinterface

interface cmpl_if import di_pkg::*; #(
  parameter int SEQ_BITS = 5
) ();

  logic                 val;
  logic [SEQ_BITS-1:0]  seq;
  logic [4:0]           waddr;
  logic [XLEN-1:0]      wdata;
  logic                 wen;

  modport source (output val, seq, waddr, wdata, wen);
  modport sink (input val, seq, waddr, wdata, wen);

endinterface

//--- hw/inst_decoder.sv
// Combinational decoder for the held instruction.
// Recognizes add, addi, mul and lw; anything else drops legal.
// Field outputs are still driven for illegal encodings.

`timescale 1ns/100ps

module inst_decoder import di_pkg::*; (
  input  logic [31:0]    inst,
  dec_if.producer        dec
);

  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // ------------------------------------------------------------
  // Register fields and I-type immediate
  // ------------------------------------------------------------

  assign dec.rd  = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];
  assign dec.imm = {{(XLEN-12){inst[31]}}, inst[31:20]};

  // ------------------------------------------------------------
  // Opcode decode
  // ------------------------------------------------------------

  always_comb begin
    dec.uop      = OP_ADD;
    dec.uses_rs2 = 1'b0;
    dec.legal    = 1'b0;

    case (opcode)
      OPC_OP: begin
        dec.uses_rs2 = 1'b1;
        if (funct3 == FUNCT3_ADD && funct7 == FUNCT7_ADD) begin
          dec.uop   = OP_ADD;
          dec.legal = 1'b1;
        end else if (funct3 == FUNCT3_ADD && funct7 == FUNCT7_MULDIV) begin
          // mul shares funct3 with add, funct7 tells them apart
          dec.uop   = OP_MUL;
          dec.legal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == FUNCT3_ADD) begin
          dec.uop   = OP_ADDI;
          dec.legal = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == FUNCT3_LW) begin
          dec.uop   = OP_LW;
          dec.legal = 1'b1;
        end
      end
      default: begin
        dec.legal = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/reg_file.sv
// 32 x XLEN register file, two asynchronous reads, one write.
// Writes come from the completion bundle; x0 always reads zero.
// No bypass, so a written value shows up one cycle later.

`timescale 1ns/100ps

module reg_file import di_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  dec_if.reader            dec,
  cmpl_if.sink             cmpl,
  output logic [XLEN-1:0]  rdata1,
  output logic [XLEN-1:0]  rdata2
);

  logic [XLEN-1:0] regs [32];
  logic            we;

  // Writes to x0 are dropped here
  assign we = cmpl.val && cmpl.wen && (cmpl.waddr != 5'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[cmpl.waddr] <= cmpl.wdata;
    end
  end

  // Read ports
  assign rdata1 = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rdata2 = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

//--- hw/scoreboard.sv
// Pending-write table, one bit and one sequence tag per register.
// x0 is never marked pending, so completions to x0 are ignored.
// Only one writer per register can be in flight (WAW stalls issue).

`timescale 1ns/100ps

module scoreboard #(
  parameter int SEQ_BITS = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 set_val,
  input  logic [4:0]           set_reg,
  input  logic [SEQ_BITS-1:0]  set_seq,
  cmpl_if.sink                 cmpl,
  output logic [31:0]          pending
);

  logic [SEQ_BITS-1:0] tag [32];
  logic                clr_val;
  logic                do_set;

  assign do_set  = set_val && (set_reg != 5'd0);

  // Completion must match both the register and its tag
  assign clr_val = cmpl.val && pending[cmpl.waddr] && (tag[cmpl.waddr] == cmpl.seq);

  // ------------------------------------------------------------
  // Pending bits
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (clr_val) begin
        pending[cmpl.waddr] <= 1'b0;
      end
      // Set wins, though issue never targets a pending register
      if (do_set) begin
        pending[set_reg] <= 1'b1;
      end
    end
  end

  // Tags are only looked at while the pending bit is set
  always_ff @(posedge clk) begin
    if (do_set) begin
      tag[set_reg] <= set_seq;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Every real writeback has to belong to an issued instruction
  a_cmpl_matches: assert property (
    @(posedge clk) disable iff (rst)
    cmpl.val && (cmpl.waddr != 5'd0) |-> pending[cmpl.waddr] && (tag[cmpl.waddr] == cmpl.seq)
  );

endmodule

//--- hw/issue_ctrl.sv
// Decode register, hazard stall and pipe steering.
// Holds one instruction; x_val is combinational and may depend on x_rdy.
// Pipe i wins when it is the lowest-index capable pipe with x_rdy set.

`timescale 1ns/100ps

module issue_ctrl import di_pkg::*; #(
  parameter int                         NUM_PIPES = 3,
  parameter op_vec_t [NUM_PIPES-1:0]    PIPE_OPS  = {NUM_PIPES{OP_ALL_VEC}},
  parameter int                         SEQ_BITS  = 5
) (
  input  logic                  clk,
  input  logic                  rst,

  // Fetch side
  input  logic                  f_val,
  output logic                  f_rdy,
  input  logic [XLEN-1:0]       f_pc,
  input  logic [31:0]           f_inst,

  // Held instruction towards the decoder
  output logic [31:0]           inst,
  dec_if.consumer               dec,
  input  logic [XLEN-1:0]       rdata1,
  input  logic [XLEN-1:0]       rdata2,

  // Scoreboard
  input  logic [31:0]           pending,
  output logic                  set_val,
  output logic [4:0]            set_reg,
  output logic [SEQ_BITS-1:0]   set_seq,

  // Execute side
  output logic [NUM_PIPES-1:0]  x_val,
  input  logic [NUM_PIPES-1:0]  x_rdy,
  output logic [XLEN-1:0]       x_pc,
  output logic [XLEN-1:0]       x_op1,
  output logic [XLEN-1:0]       x_op2,
  output logic [4:0]            x_waddr,
  output uop_t                  x_uop,
  output logic [SEQ_BITS-1:0]   x_seq
);

  logic                  d_val;
  logic [31:0]           d_inst;
  logic [XLEN-1:0]       d_pc;
  logic [SEQ_BITS-1:0]   seq_cnt;

  logic                  hazard;
  logic [NUM_PIPES-1:0]  capable;
  logic [NUM_PIPES-1:0]  cand;
  logic [NUM_PIPES-1:0]  grant;
  logic                  issue;
  logic                  f_fire;

  // ------------------------------------------------------------
  // Decode register
  // ------------------------------------------------------------

  assign f_fire = f_val && f_rdy;
  assign f_rdy  = !d_val || issue;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (f_fire) begin
      d_val <= 1'b1;
    end else if (issue) begin
      d_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f_fire) begin
      d_inst <= f_inst;
      d_pc   <= f_pc;
    end
  end

  assign inst = d_inst;

  // ------------------------------------------------------------
  // Hazards and steering
  // ------------------------------------------------------------

  // x0 never shows up as pending
  assign hazard = pending[dec.rs1] || (dec.uses_rs2 && pending[dec.rs2]) || pending[dec.rd];

  for (genvar i = 0; i < NUM_PIPES; i++) begin : g_cap
    assign capable[i] = |(PIPE_OPS[i] & uop_to_vec(dec.uop));
  end

  // Lowest set bit of the candidate mask
  assign cand  = capable & x_rdy;
  assign grant = cand & (~cand + NUM_PIPES'(1));

  assign x_val = (d_val && !hazard) ? grant : '0;
  assign issue = |x_val;

  // ------------------------------------------------------------
  // Payload and sequence numbers
  // ------------------------------------------------------------

  assign x_pc    = d_pc;
  assign x_op1   = rdata1;
  assign x_op2   = dec.uses_rs2 ? rdata2 : dec.imm;
  assign x_waddr = dec.rd;
  assign x_uop   = dec.uop;
  assign x_seq   = seq_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      seq_cnt <= '0;
    end else if (issue) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  assign set_val = issue;
  assign set_reg = dec.rd;
  assign set_seq = seq_cnt;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  a_one_pipe: assert property (@(posedge clk) disable iff (rst) $onehot0(x_val));

  // Illegal encodings are not trapped, the fetch side must not send them
  a_legal: assert property (@(posedge clk) disable iff (rst) d_val |-> dec.legal);

endmodule

//--- hw/decode_issue_unit.sv
// Decode-issue stage top level with plain ports on every side.
// Execute payload is shared by all pipes; x_val picks the pipe.
// Completions have no ready and arrive at most one per cycle.

`timescale 1ns/100ps

module decode_issue_unit import di_pkg::*; #(
  parameter int                         NUM_PIPES = 3,
  parameter op_vec_t [NUM_PIPES-1:0]    PIPE_OPS  = {NUM_PIPES{OP_ALL_VEC}},
  parameter int                         SEQ_BITS  = 5
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  f_val,
  output logic                  f_rdy,
  input  logic [XLEN-1:0]       f_pc,
  input  logic [31:0]           f_inst,

  output logic [NUM_PIPES-1:0]  x_val,
  input  logic [NUM_PIPES-1:0]  x_rdy,
  output logic [XLEN-1:0]       x_pc,
  output logic [XLEN-1:0]       x_op1,
  output logic [XLEN-1:0]       x_op2,
  output logic [4:0]            x_waddr,
  output uop_t                  x_uop,
  output logic [SEQ_BITS-1:0]   x_seq,

  input  logic                  cmpl_val,
  input  logic [SEQ_BITS-1:0]   cmpl_seq,
  input  logic [4:0]            cmpl_waddr,
  input  logic [XLEN-1:0]       cmpl_wdata,
  input  logic                  cmpl_wen
);

  dec_if                          dec ();
  cmpl_if #(.SEQ_BITS(SEQ_BITS))  cmpl ();

  logic [31:0]          inst;
  logic [XLEN-1:0]      rdata1;
  logic [XLEN-1:0]      rdata2;
  logic [31:0]          pending;
  logic                 set_val;
  logic [4:0]           set_reg;
  logic [SEQ_BITS-1:0]  set_seq;

  // Completion ports into the bundle
  assign cmpl.val   = cmpl_val;
  assign cmpl.seq   = cmpl_seq;
  assign cmpl.waddr = cmpl_waddr;
  assign cmpl.wdata = cmpl_wdata;
  assign cmpl.wen   = cmpl_wen;

  inst_decoder u_dec (
    .inst (inst),
    .dec  (dec)
  );

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .dec    (dec),
    .cmpl   (cmpl),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  scoreboard #(.SEQ_BITS(SEQ_BITS)) u_sb (
    .clk     (clk),
    .rst     (rst),
    .set_val (set_val),
    .set_reg (set_reg),
    .set_seq (set_seq),
    .cmpl    (cmpl),
    .pending (pending)
  );

  issue_ctrl #(
    .NUM_PIPES (NUM_PIPES),
    .PIPE_OPS  (PIPE_OPS),
    .SEQ_BITS  (SEQ_BITS)
  ) u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .f_val   (f_val),
    .f_rdy   (f_rdy),
    .f_pc    (f_pc),
    .f_inst  (f_inst),
    .inst    (inst),
    .dec     (dec),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .pending (pending),
    .set_val (set_val),
    .set_reg (set_reg),
    .set_seq (set_seq),
    .x_val   (x_val),
    .x_rdy   (x_rdy),
    .x_pc    (x_pc),
    .x_op1   (x_op1),
    .x_op2   (x_op2),
    .x_waddr (x_waddr),
    .x_uop   (x_uop),
    .x_seq   (x_seq)
  );

endmodule

//--- dv/tb_clk_gen.sv
// Clock and reset source for the testbench.
// Reset is high from time zero through the first RESET_CYCLES rising edges.

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- dv/decode_issue_tb.sv
// Random add/addi/mul/lw stream on x0..x7 against an in-order model.
// Pipe 0 takes all ops, pipe 1 all but mul, pipe 2 mul only.
// Completions return 1 to 8 cycles after issue, one per cycle.

`timescale 1ns/100ps

module decode_issue_tb import di_pkg::*; ();

  localparam int NUM_PIPES      = 3;
  localparam int SEQ_BITS       = 5;
  localparam int NUM_INSTS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 20 + 100;
  localparam op_vec_t [NUM_PIPES-1:0] PIPE_OPS =
    {OP_MUL_VEC, OP_ALL_VEC & ~OP_MUL_VEC, OP_ALL_VEC};

  logic                  clk;
  logic                  rst;
  logic                  f_val;
  logic                  f_rdy;
  logic [XLEN-1:0]       f_pc;
  logic [31:0]           f_inst;
  logic [NUM_PIPES-1:0]  x_val;
  logic [NUM_PIPES-1:0]  x_rdy;
  logic [XLEN-1:0]       x_pc;
  logic [XLEN-1:0]       x_op1;
  logic [XLEN-1:0]       x_op2;
  logic [4:0]            x_waddr;
  uop_t                  x_uop;
  logic [SEQ_BITS-1:0]   x_seq;
  logic                  cmpl_val;
  logic [SEQ_BITS-1:0]   cmpl_seq;
  logic [4:0]            cmpl_waddr;
  logic [XLEN-1:0]       cmpl_wdata;
  logic                  cmpl_wen;

  // Program-order stream with operands and results from the model
  logic [31:0]  ref_inst [NUM_INSTS];
  logic [31:0]  ref_pc   [NUM_INSTS];
  uop_t         ref_uop  [NUM_INSTS];
  logic [4:0]   ref_rd   [NUM_INSTS];
  logic [4:0]   ref_rs1  [NUM_INSTS];
  logic [4:0]   ref_rs2  [NUM_INSTS];
  logic         ref_use2 [NUM_INSTS];
  logic [31:0]  ref_op1  [NUM_INSTS];
  logic [31:0]  ref_op2  [NUM_INSTS];
  logic [31:0]  ref_res  [NUM_INSTS];

  integer       seed;
  int           fetch_cnt;
  int           issue_cnt;
  int           done_cnt;
  int           cycle_cnt;
  int           in_flight [32];
  int           wait_idx [$];
  int           wait_due [$];
  int           cur_cmpl;
  int           mismatch_cnt;
  int           protocol_cnt;
  int           timeout_cnt;
  bit           done;
  bit           timed_out;
  bit           first_cycle;
  bit           prev_stall;
  bit           prev_no_hazard;
  logic [31:0]  prev_pc;
  uop_t         prev_uop;
  logic [4:0]   prev_waddr;
  logic [SEQ_BITS-1:0] prev_seq;
  logic [31:0]  prev_op1;
  logic [31:0]  prev_op2;

  tb_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  decode_issue_unit #(
    .NUM_PIPES (NUM_PIPES),
    .PIPE_OPS  (PIPE_OPS),
    .SEQ_BITS  (SEQ_BITS)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .f_val      (f_val),
    .f_rdy      (f_rdy),
    .f_pc       (f_pc),
    .f_inst     (f_inst),
    .x_val      (x_val),
    .x_rdy      (x_rdy),
    .x_pc       (x_pc),
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_waddr    (x_waddr),
    .x_uop      (x_uop),
    .x_seq      (x_seq),
    .cmpl_val   (cmpl_val),
    .cmpl_seq   (cmpl_seq),
    .cmpl_waddr (cmpl_waddr),
    .cmpl_wdata (cmpl_wdata),
    .cmpl_wen   (cmpl_wen)
  );

  // ------------------------------------------------------------
  // Checking helpers and reference model
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_rule(input bit ok, input string what);
    assert (ok) else begin
      $display("Error at cycle %0d: %s", cycle_cnt, what);
      protocol_cnt++;
    end
  endtask

  function automatic bit pipe_accepts(input int pipe, input uop_t uop);
    case (pipe)
      0:       return 1'b1;
      1:       return uop != OP_MUL;
      2:       return uop == OP_MUL;
      default: return 1'b0;
    endcase
  endfunction

  // x0 never enters in_flight
  function automatic bit blocked_by_pending(input int k);
    return in_flight[ref_rs1[k]] > 0 || (ref_use2[k] && in_flight[ref_rs2[k]] > 0) ||
           in_flight[ref_rd[k]] > 0;
  endfunction

  // Builds the stream and runs it through the model in program order
  task automatic build_stream();
    logic [31:0] regs [32];
    logic [31:0] rnd;
    logic [11:0] imm;
    logic [31:0] imm_ext;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int k = 0; k < NUM_INSTS; k++) begin
      rnd         = $random(seed);
      imm         = rnd[31:20];
      imm_ext     = {{20{imm[11]}}, imm};
      ref_rd[k]   = {2'b00, rnd[2:0]};
      ref_rs1[k]  = {2'b00, rnd[5:3]};
      ref_rs2[k]  = {2'b00, rnd[8:6]};
      ref_uop[k]  = uop_t'(rnd[10:9]);
      ref_pc[k]   = 32'h0000_1000 + 32'(4 * k);
      ref_use2[k] = (ref_uop[k] == OP_ADD) || (ref_uop[k] == OP_MUL);
      case (ref_uop[k])
        OP_ADD:  ref_inst[k] = {7'b0000000, ref_rs2[k], ref_rs1[k], 3'b000, ref_rd[k], OPC_OP};
        OP_MUL:  ref_inst[k] = {FUNCT7_MULDIV, ref_rs2[k], ref_rs1[k], 3'b000, ref_rd[k], OPC_OP};
        OP_ADDI: ref_inst[k] = {imm, ref_rs1[k], 3'b000, ref_rd[k], OPC_OP_IMM};
        default: ref_inst[k] = {imm, ref_rs1[k], 3'b010, ref_rd[k], OPC_LOAD};
      endcase
      ref_op1[k] = regs[ref_rs1[k]];
      ref_op2[k] = ref_use2[k] ? regs[ref_rs2[k]] : imm_ext;
      case (ref_uop[k])
        OP_MUL:  ref_res[k] = ref_op1[k] * ref_op2[k];
        // Load data is a fixed function of the address
        OP_LW:   ref_res[k] = (ref_op1[k] + ref_op2[k]) ^ 32'h5a5a5a5a;
        default: ref_res[k] = ref_op1[k] + ref_op2[k];
      endcase
      if (ref_rd[k] != 5'd0) begin
        regs[ref_rd[k]] = ref_res[k];
      end
    end
  endtask

  // ------------------------------------------------------------
  // Per-cycle checks and stimulus
  // ------------------------------------------------------------

  always @(posedge clk) begin : cycle_step
    logic [NUM_PIPES-1:0] fire;
    int  pipe;
    int  k;
    int  pick;
    bit  held;
    if (rst) begin
      f_val    <= 1'b0;
      x_rdy    <= '0;
      cmpl_val <= 1'b0;
    end else begin
      cycle_cnt++;
      if (first_cycle) begin
        check_rule(x_val == '0, "x_val is high right after reset");
        check_rule(f_rdy == 1'b1, "f_rdy is low right after reset");
        first_cycle = 1'b0;
      end
      fire = x_val & x_rdy;
      held = fetch_cnt > issue_cnt;
      k    = issue_cnt;

      check_rule((x_val & (x_val - 1'b1)) == '0, "more than one x_val bit is high");
      if (x_val != '0) begin
        check_rule(k < NUM_INSTS, "x_val is high with no instruction left in the stream");
        if (k < NUM_INSTS) begin
          check_rule(!blocked_by_pending(k), $sformatf(
            "instruction %0d offered while one of its registers is pending", k));
        end
      end

      if (fire != '0 && k < NUM_INSTS) begin
        check_value($sformatf("issue %0d x_pc", k), ref_pc[k], x_pc);
        check_value($sformatf("issue %0d x_uop", k), ref_uop[k], x_uop);
        check_value($sformatf("issue %0d x_waddr", k), ref_rd[k], x_waddr);
        check_value($sformatf("issue %0d x_op1", k), ref_op1[k], x_op1);
        check_value($sformatf("issue %0d x_op2", k), ref_op2[k], x_op2);
        check_value($sformatf("issue %0d x_seq", k), k % (1 << SEQ_BITS), x_seq);
        pipe = 0;
        for (int p = NUM_PIPES - 1; p >= 0; p--) begin
          if (fire[p]) pipe = p;
        end
        check_rule(pipe_accepts(pipe, ref_uop[k]), $sformatf(
          "instruction %0d went to pipe %0d, which cannot run it", k, pipe));
        for (int p = 0; p < pipe; p++) begin
          check_rule(!(pipe_accepts(p, ref_uop[k]) && x_rdy[p]), $sformatf(
            "instruction %0d skipped ready capable pipe %0d", k, p));
        end
        issue_cnt++;
        if (ref_rd[k] != 5'd0) in_flight[ref_rd[k]]++;
        // Due cycle gives a writeback 1 to 8 edges after issue
        wait_idx.push_back(k);
        wait_due.push_back(cycle_cnt + ($random(seed) & 7));
      end

      // Back-pressure holds the decode register and its payload
      if (held && x_val == '0) begin
        check_rule(!f_rdy, "f_rdy is high while the decode register is stalled");
      end
      if (prev_stall) begin
        check_value($sformatf("hold x_pc, cycle %0d", cycle_cnt), prev_pc, x_pc);
        check_value($sformatf("hold x_uop, cycle %0d", cycle_cnt), prev_uop, x_uop);
        check_value($sformatf("hold x_waddr, cycle %0d", cycle_cnt), prev_waddr, x_waddr);
        check_value($sformatf("hold x_seq, cycle %0d", cycle_cnt), prev_seq, x_seq);
        // Source registers were not pending, so no writeback could touch them
        if (prev_no_hazard) begin
          check_value($sformatf("hold x_op1, cycle %0d", cycle_cnt), prev_op1, x_op1);
          check_value($sformatf("hold x_op2, cycle %0d", cycle_cnt), prev_op2, x_op2);
        end
      end
      prev_stall     = held && (fire == '0);
      prev_no_hazard = prev_stall && !blocked_by_pending(k);
      prev_pc        = x_pc;
      prev_uop       = x_uop;
      prev_waddr     = x_waddr;
      prev_seq       = x_seq;
      prev_op1       = x_op1;
      prev_op2       = x_op2;

      if (f_val && f_rdy) fetch_cnt++;

      // Writeback presented last cycle lands at this edge
      if (cur_cmpl >= 0) begin
        if (ref_rd[cur_cmpl] != 5'd0) in_flight[ref_rd[cur_cmpl]]--;
        done_cnt++;
      end
      pick = -1;
      foreach (wait_due[i]) begin
        if (pick < 0 && wait_due[i] <= cycle_cnt) pick = i;
      end
      if (pick >= 0) begin
        cur_cmpl = wait_idx[pick];
        wait_idx.delete(pick);
        wait_due.delete(pick);
        cmpl_val   <= 1'b1;
        cmpl_seq   <= SEQ_BITS'(cur_cmpl);
        cmpl_waddr <= ref_rd[cur_cmpl];
        cmpl_wdata <= ref_res[cur_cmpl];
        cmpl_wen   <= 1'b1;
      end else begin
        cur_cmpl = -1;
        cmpl_val <= 1'b0;
        cmpl_wen <= 1'b0;
      end

      // An offered beat stays until it is taken
      if (!(f_val && !f_rdy)) begin
        if (fetch_cnt < NUM_INSTS) begin
          f_val  <= ($random(seed) & 3) != 0;
          f_pc   <= ref_pc[fetch_cnt];
          f_inst <= ref_inst[fetch_cnt];
        end else begin
          f_val <= 1'b0;
        end
      end
      x_rdy <= NUM_PIPES'($random(seed));

      if (done_cnt == NUM_INSTS) done = 1'b1;
      if (cycle_cnt >= TIMEOUT_CYCLES) timed_out = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------

  initial begin
    seed           = 32'h623b291a;
    f_val          = 1'b0;
    f_pc           = '0;
    f_inst         = '0;
    x_rdy          = '0;
    cmpl_val       = 1'b0;
    cmpl_seq       = '0;
    cmpl_waddr     = '0;
    cmpl_wdata     = '0;
    cmpl_wen       = 1'b0;
    fetch_cnt      = 0;
    issue_cnt      = 0;
    done_cnt       = 0;
    cycle_cnt      = 0;
    cur_cmpl       = -1;
    mismatch_cnt   = 0;
    protocol_cnt   = 0;
    timeout_cnt    = 0;
    done           = 1'b0;
    timed_out      = 1'b0;
    first_cycle    = 1'b1;
    prev_stall     = 1'b0;
    prev_no_hazard = 1'b0;
    for (int r = 0; r < 32; r++) begin
      in_flight[r] = 0;
    end
    build_stream();

    wait (done || timed_out);
    assert (done) else begin
      $display("Timeout after %0d cycles with %0d issued and %0d completed",
               cycle_cnt, issue_cnt, done_cnt);
      timeout_cnt++;
    end
    check_value("total issued", NUM_INSTS, issue_cnt);
    $display("Errors: %0d mismatch, %0d protocol, %0d timeout",
             mismatch_cnt, protocol_cnt, timeout_cnt);
    if (mismatch_cnt + protocol_cnt + timeout_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/di_pkg.sv
hw/di_ifs.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/scoreboard.sv
hw/issue_ctrl.sv
hw/decode_issue_unit.sv
dv/tb_clk_gen.sv
dv/decode_issue_tb.sv
